//--- list.f
+incdir+source
source/decode_pkg.sv
source/register_file.sv
source/instruction_decoder.sv
source/load_use_detector.sv
source/decode.sv
source/decode_top.sv
tb/decode_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the decode testbench with verilator and run it.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module decode_tb -o decode_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/decode_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "TEST PASS"; then
    exit 0
fi
exit 1

//--- source/decode.sv
`default_nettype none

`include "decode_params.svh"

module decode (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire [`DEC_XLEN-1:0]         instr,
    input  wire [`DEC_XLEN-1:0]         curr_pc,
    input  wire [`DEC_XLEN-1:0]         next_pc,
    input  wire decode_pkg::wb_port_t   wb,
    input  wire                         stall_mem,
    input  wire                         flush,
    input  wire                         hazard,
    output decode_pkg::id_ex_t          id_ex
);

    decode_pkg::ctrl_t      ctrl;
    decode_pkg::imm_fmt_e   imm_fmt;
    decode_pkg::id_ex_t     id_ex_d;
    logic [`DEC_XLEN-1:0]   rf_rs1_data;
    logic [`DEC_XLEN-1:0]   rf_rs2_data;
    logic [`DEC_XLEN-1:0]   imm;

    register_file reg_file_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1      (instr[19:15]),
        .rs2      (instr[24:20]),
        .wb       (wb),
        .rs1_data (rf_rs1_data),
        .rs2_data (rf_rs2_data)
    );

    instruction_decoder decoder_i (
        .instr   (instr),
        .ctrl    (ctrl),
        .imm_fmt (imm_fmt)
    );

    // ##################################################################
    // immediate generation
    // ##################################################################

    always_comb begin
        case (imm_fmt)
            decode_pkg::IMM_S: imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            decode_pkg::IMM_B: imm = {{19{instr[31]}}, instr[31], instr[7],
                                      instr[30:25], instr[11:8], 1'b0};
            decode_pkg::IMM_U: imm = {instr[31:12], 12'b0};
            decode_pkg::IMM_J: imm = {{11{instr[31]}}, instr[31], instr[19:12],
                                      instr[20], instr[30:21], 1'b0};
            default:           imm = {{20{instr[31]}}, instr[31:20]};
        endcase
    end

    // ##################################################################
    // id/ex register
    // ##################################################################

    // next entry, or a bubble on flush or load-use.
    always_comb begin
        id_ex_d = '0;
        if (flush || hazard) begin
            id_ex_d.instr = `DEC_NOP_INSTR;
        end else begin
            id_ex_d.ctrl     = ctrl;
            id_ex_d.rs1_data = ctrl.op_a_pc ? curr_pc : rf_rs1_data;
            id_ex_d.rs2_data = rf_rs2_data;
            id_ex_d.imm      = imm;
            id_ex_d.curr_pc  = curr_pc;
            id_ex_d.next_pc  = next_pc;
            id_ex_d.rs1      = instr[19:15];
            id_ex_d.rs2      = instr[24:20];
            id_ex_d.rd       = instr[11:7];
            id_ex_d.instr    = instr;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            id_ex <= '0;
        end else if (!stall_mem) begin
            id_ex <= id_ex_d;
        end
    end

endmodule

`default_nettype wire

//--- source/decode_params.svh
`ifndef DECODE_PARAMS_SVH
`define DECODE_PARAMS_SVH

// datapath and pc width.
`define DEC_XLEN 32

// register file geometry.
`define DEC_REG_COUNT 32
`define DEC_REG_AW 5

// addi x0, x0, 0 used for pipeline bubbles.
`define DEC_NOP_INSTR 32'h0000_0013

`endif

//--- source/decode_pkg.sv
`default_nettype none

`include "decode_params.svh"

package decode_pkg;

    // ##################################################################
    // encodings
    // ##################################################################

    // rv32i major opcodes, instr[6:0].
    typedef enum logic [6:0] {
        OPC_LOAD   = 7'b000_0011,
        OPC_STORE  = 7'b010_0011,
        OPC_BRANCH = 7'b110_0011,
        OPC_JAL    = 7'b110_1111,
        OPC_JALR   = 7'b110_0111,
        OPC_OP_IMM = 7'b001_0011,
        OPC_OP     = 7'b011_0011,
        OPC_LUI    = 7'b011_0111,
        OPC_AUIPC  = 7'b001_0111
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B
    } alu_op_e;

    // branch and jump kinds resolved in execute.
    typedef enum logic [3:0] {
        BR_NONE,
        BR_BEQ,
        BR_BNE,
        BR_BLT,
        BR_BGE,
        BR_BLTU,
        BR_BGEU,
        BR_JAL,
        BR_JALR
    } branch_e;

    typedef enum logic [1:0] {
        WB_ALU,
        WB_MEM,
        WB_PC4
    } wb_sel_e;

    typedef enum logic [2:0] {
        IMM_I,
        IMM_S,
        IMM_B,
        IMM_U,
        IMM_J
    } imm_fmt_e;

    // ##################################################################
    // bundles
    // ##################################################################

    typedef struct packed {
        alu_op_e    alu_op;
        branch_e    branch;
        wb_sel_e    wb_sel;
        logic       reg_write;
        logic       mem_read;
        logic       mem_write;
        logic [1:0] mem_width;    // 0 byte, 1 half, 2 word.
        logic       mem_unsigned;
        logic       op_a_pc;
        logic       op_b_imm;
        logic       illegal;
    } ctrl_t;

    typedef struct packed {
        ctrl_t                  ctrl;
        logic [`DEC_XLEN-1:0]   rs1_data;
        logic [`DEC_XLEN-1:0]   rs2_data;
        logic [`DEC_XLEN-1:0]   imm;
        logic [`DEC_XLEN-1:0]   curr_pc;
        logic [`DEC_XLEN-1:0]   next_pc;
        logic [`DEC_REG_AW-1:0] rs1;
        logic [`DEC_REG_AW-1:0] rs2;
        logic [`DEC_REG_AW-1:0] rd;
        logic [`DEC_XLEN-1:0]   instr;
    } id_ex_t;

    // write-back port from the end of the pipeline.
    typedef struct packed {
        logic                   en;
        logic [`DEC_REG_AW-1:0] rd;
        logic [`DEC_XLEN-1:0]   data;
    } wb_port_t;

endpackage

`default_nettype wire

//--- source/decode_top.sv
`default_nettype none

`include "decode_params.svh"

module decode_top (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire [`DEC_XLEN-1:0]         instr,
    input  wire [`DEC_XLEN-1:0]         curr_pc,
    input  wire [`DEC_XLEN-1:0]         next_pc,
    input  wire decode_pkg::wb_port_t   wb,
    input  wire                         stall_mem,
    input  wire                         flush,
    output decode_pkg::id_ex_t          id_ex,
    output logic                        stall_fetch
);

    // the load-use hazard both bubbles id/ex and holds fetch.
    decode decode_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .instr     (instr),
        .curr_pc   (curr_pc),
        .next_pc   (next_pc),
        .wb        (wb),
        .stall_mem (stall_mem),
        .flush     (flush),
        .hazard    (stall_fetch),
        .id_ex     (id_ex)
    );

    load_use_detector load_use_i (
        .id_ex  (id_ex),
        .instr  (instr),
        .hazard (stall_fetch)
    );

endmodule

`default_nettype wire

//--- source/instruction_decoder.sv
`default_nettype none

`include "decode_params.svh"

module instruction_decoder (
    input  wire [`DEC_XLEN-1:0]     instr,
    output decode_pkg::ctrl_t       ctrl,
    output decode_pkg::imm_fmt_e    imm_fmt
);

    decode_pkg::opcode_e opcode;
    logic [2:0]          funct3;
    logic                funct7_b5;

    assign opcode    = decode_pkg::opcode_e'(instr[6:0]);
    assign funct3    = instr[14:12];
    assign funct7_b5 = instr[30];

    // alu op shared by op and op-imm; sub only exists in register form.
    function automatic decode_pkg::alu_op_e alu_from_funct(
        input logic [2:0] f3,
        input logic       b30,
        input logic       reg_form
    );
        decode_pkg::alu_op_e op;
        case (f3)
            3'b000:  op = (reg_form && b30) ? decode_pkg::ALU_SUB : decode_pkg::ALU_ADD;
            3'b001:  op = decode_pkg::ALU_SLL;
            3'b010:  op = decode_pkg::ALU_SLT;
            3'b011:  op = decode_pkg::ALU_SLTU;
            3'b100:  op = decode_pkg::ALU_XOR;
            3'b101:  op = b30 ? decode_pkg::ALU_SRA : decode_pkg::ALU_SRL;
            3'b110:  op = decode_pkg::ALU_OR;
            default: op = decode_pkg::ALU_AND;
        endcase
        return op;
    endfunction

    always_comb begin
        ctrl    = '0;
        imm_fmt = decode_pkg::IMM_I;

        case (opcode)
            decode_pkg::OPC_OP_IMM: begin
                ctrl.alu_op    = alu_from_funct(funct3, funct7_b5, 1'b0);
                ctrl.op_b_imm  = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            decode_pkg::OPC_OP: begin
                ctrl.alu_op    = alu_from_funct(funct3, funct7_b5, 1'b1);
                ctrl.reg_write = 1'b1;
            end
            decode_pkg::OPC_LUI: begin
                ctrl.alu_op    = decode_pkg::ALU_PASS_B;
                ctrl.op_b_imm  = 1'b1;
                ctrl.reg_write = 1'b1;
                imm_fmt        = decode_pkg::IMM_U;
            end
            decode_pkg::OPC_AUIPC: begin
                ctrl.op_a_pc   = 1'b1;
                ctrl.op_b_imm  = 1'b1;
                ctrl.reg_write = 1'b1;
                imm_fmt        = decode_pkg::IMM_U;
            end
            decode_pkg::OPC_LOAD: begin
                // lb lh lw lbu lhu only.
                if ((funct3 == 3'b011) || (funct3[2:1] == 2'b11)) begin
                    ctrl.illegal = 1'b1;
                end else begin
                    ctrl.mem_read     = 1'b1;
                    ctrl.mem_width    = funct3[1:0];
                    ctrl.mem_unsigned = funct3[2];
                    ctrl.op_b_imm     = 1'b1;
                    ctrl.reg_write    = 1'b1;
                    ctrl.wb_sel       = decode_pkg::WB_MEM;
                end
            end
            decode_pkg::OPC_STORE: begin
                if (funct3[2] || (funct3[1:0] == 2'b11)) begin
                    ctrl.illegal = 1'b1;
                end else begin
                    ctrl.mem_write = 1'b1;
                    ctrl.mem_width = funct3[1:0];
                    ctrl.op_b_imm  = 1'b1;
                    imm_fmt        = decode_pkg::IMM_S;
                end
            end
            decode_pkg::OPC_BRANCH: begin
                ctrl.op_a_pc  = 1'b1;
                ctrl.op_b_imm = 1'b1;
                imm_fmt       = decode_pkg::IMM_B;
                case (funct3)
                    3'b000:  ctrl.branch = decode_pkg::BR_BEQ;
                    3'b001:  ctrl.branch = decode_pkg::BR_BNE;
                    3'b100:  ctrl.branch = decode_pkg::BR_BLT;
                    3'b101:  ctrl.branch = decode_pkg::BR_BGE;
                    3'b110:  ctrl.branch = decode_pkg::BR_BLTU;
                    3'b111:  ctrl.branch = decode_pkg::BR_BGEU;
                    default: ctrl.illegal = 1'b1;
                endcase
            end
            decode_pkg::OPC_JAL: begin
                ctrl.branch    = decode_pkg::BR_JAL;
                ctrl.op_a_pc   = 1'b1;
                ctrl.op_b_imm  = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.wb_sel    = decode_pkg::WB_PC4;
                imm_fmt        = decode_pkg::IMM_J;
            end
            decode_pkg::OPC_JALR: begin
                ctrl.branch    = decode_pkg::BR_JALR;
                ctrl.op_b_imm  = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.wb_sel    = decode_pkg::WB_PC4;
            end
            default: begin
                ctrl.illegal = 1'b1;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- source/load_use_detector.sv
`default_nettype none

`include "decode_params.svh"

module load_use_detector (
    input  wire decode_pkg::id_ex_t  id_ex,
    input  wire [`DEC_XLEN-1:0]      instr,
    output logic                     hazard
);

    logic [`DEC_REG_AW-1:0] rs1;
    logic [`DEC_REG_AW-1:0] rs2;
    logic                   load_pending;

    assign rs1 = instr[19:15];
    assign rs2 = instr[24:20];

    // loads to x0 never produce data worth waiting for.
    assign load_pending = id_ex.ctrl.mem_read && (id_ex.rd != '0);

    assign hazard = load_pending && ((id_ex.rd == rs1) || (id_ex.rd == rs2));

endmodule

`default_nettype wire

//--- source/register_file.sv
`default_nettype none

`include "decode_params.svh"

module register_file (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire [`DEC_REG_AW-1:0]       rs1,
    input  wire [`DEC_REG_AW-1:0]       rs2,
    input  wire decode_pkg::wb_port_t   wb,
    output logic [`DEC_XLEN-1:0]        rs1_data,
    output logic [`DEC_XLEN-1:0]        rs2_data
);

    logic [`DEC_XLEN-1:0] regs [`DEC_REG_COUNT];

    // x0 reads zero and a same-cycle write is forwarded.
    function automatic logic [`DEC_XLEN-1:0] read_port(
        input logic [`DEC_REG_AW-1:0] addr,
        input logic [`DEC_XLEN-1:0]   stored,
        input decode_pkg::wb_port_t   port
    );
        logic [`DEC_XLEN-1:0] value;
        if (addr == '0) begin
            value = '0;
        end else if (port.en && (port.rd == addr)) begin
            value = port.data;
        end else begin
            value = stored;
        end
        return value;
    endfunction

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `DEC_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.en && (wb.rd != '0)) begin
            regs[wb.rd] <= wb.data;
        end
    end

    assign rs1_data = read_port(rs1, regs[rs1], wb);
    assign rs2_data = read_port(rs2, regs[rs2], wb);

endmodule

`default_nettype wire

//--- tb/decode_stim.txt
# stimulus: name check instr curr_pc next_pc wb_en wb_rd wb_data stall_mem flush
# expected: alu_op branch wb_sel reg_write mem_read mem_write mem_width mem_unsigned op_a_pc
#   op_b_imm illegal rs1_data rs2_data imm curr_pc next_pc rs1 rs2 rd instr stall_fetch
# id_ex is seen after the edge, stall_fetch in the cycle before it.
reset 1 00000013 00000000 00000004 0 00 00000000 1 0
0 0 0 0 0 0 0 0 0 0 0 00000000 00000000 00000000 00000000 00000000 00 00 00 00000000 0
regfile 1 00000013 00000100 00000104 1 01 00001000 0 0
0 0 0 1 0 0 0 0 0 1 0 00000000 00000000 00000000 00000100 00000104 00 00 00 00000013 0
regfile 1 002081b3 00000104 00000108 1 02 00000022 0 0
0 0 0 1 0 0 0 0 0 0 0 00001000 00000022 00000002 00000104 00000108 01 02 03 002081b3 0
regfile 1 40200233 00000108 0000010c 1 00 deadbeef 0 0
1 0 0 1 0 0 0 0 0 0 0 00000000 00000022 00000402 00000108 0000010c 00 02 04 40200233 0
regfile 1 80000397 0000010c 00000110 0 00 00000000 0 0
0 0 0 1 0 0 0 0 1 1 0 0000010c 00000000 80000000 0000010c 00000110 00 00 07 80000397 0
decode 1 ffb08513 00000110 00000114 0 00 00000000 0 0
0 0 0 1 0 0 0 0 0 1 0 00001000 00000000 fffffffb 00000110 00000114 01 1b 0a ffb08513 0
decode 1 fe20ac23 00000114 00000118 0 00 00000000 0 0
0 0 0 0 0 1 2 0 0 1 0 00001000 00000022 fffffff8 00000114 00000118 01 02 18 fe20ac23 0
decode 1 fe2088e3 00000118 0000011c 0 00 00000000 0 0
0 1 0 0 0 0 0 0 1 1 0 00000118 00000022 fffffff0 00000118 0000011c 01 02 11 fe2088e3 0
decode 1 abcde5b7 0000011c 00000120 0 00 00000000 0 0
a 0 0 1 0 0 0 0 0 1 0 00000000 00000000 abcde000 0000011c 00000120 1b 1c 0b abcde5b7 0
decode 1 001000ef 00000120 00000124 0 00 00000000 0 0
0 7 2 1 0 0 0 0 1 1 0 00000120 00001000 00000800 00000120 00000124 00 01 01 001000ef 0
decode 1 0010a00b 00000124 00000128 0 00 00000000 0 0
0 0 0 0 0 0 0 0 0 0 1 00001000 00001000 00000001 00000124 00000128 01 01 00 0010a00b 0
flush 1 002081b3 00000128 0000012c 0 00 00000000 0 1
0 0 0 0 0 0 0 0 0 0 0 00000000 00000000 00000000 00000000 00000000 00 00 00 00000013 0
flush 1 002081b3 0000012c 00000130 0 00 00000000 0 0
0 0 0 1 0 0 0 0 0 0 0 00001000 00000022 00000002 0000012c 00000130 01 02 03 002081b3 0
load_use 1 0040a283 00000130 00000134 0 00 00000000 0 0
0 0 1 1 1 0 2 0 0 1 0 00001000 00000000 00000004 00000130 00000134 01 04 05 0040a283 0
load_use 1 00228333 00000134 00000138 0 00 00000000 0 0
0 0 0 0 0 0 0 0 0 0 0 00000000 00000000 00000000 00000000 00000000 00 00 00 00000013 1
load_use 1 00228333 00000134 00000138 1 05 00000055 0 0
0 0 0 1 0 0 0 0 0 0 0 00000055 00000022 00000002 00000134 00000138 05 02 06 00228333 0
load_use 1 0000a003 00000138 0000013c 0 00 00000000 0 0
0 0 1 1 1 0 2 0 0 1 0 00001000 00000000 00000000 00000138 0000013c 01 00 00 0000a003 0
load_use 1 000003b3 0000013c 00000140 0 00 00000000 0 0
0 0 0 1 0 0 0 0 0 0 0 00000000 00000000 00000000 0000013c 00000140 00 00 07 000003b3 0
mem_stall 1 00168733 00000140 00000144 1 0d 0000abcd 1 0
0 0 0 1 0 0 0 0 0 0 0 00000000 00000000 00000000 0000013c 00000140 00 00 07 000003b3 0
mem_stall 1 00168733 00000140 00000144 0 00 00000000 0 0
0 0 0 1 0 0 0 0 0 0 0 0000abcd 00001000 00000001 00000140 00000144 0d 01 0e 00168733 0

//--- tb/decode_tb.sv
`default_nettype none

`include "decode_params.svh"

module decode_tb;

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 10;
    localparam int MAX_VEC      = 64;
    localparam int NUM_FIELDS   = 21;

    typedef logic [NUM_FIELDS-1:0][31:0] field_vec_t;

    logic                 clk;
    logic                 rst_n;
    logic [`DEC_XLEN-1:0] instr;
    logic [`DEC_XLEN-1:0] curr_pc;
    logic [`DEC_XLEN-1:0] next_pc;
    decode_pkg::wb_port_t wb;
    logic                 stall_mem;
    logic                 flush;
    decode_pkg::id_ex_t   id_ex;
    logic                 stall_fetch;

    // stimulus words in file order after the test name.
    string       vec_name [MAX_VEC];
    logic [31:0] vec_stim [MAX_VEC][9];
    logic [31:0] exp_f    [MAX_VEC][NUM_FIELDS];
    int          vec_count;
    int          checks;
    int          errors;
    int          test_errors;
    int          tests_passed;
    int          tests_failed;
    logic        load_ok;
    logic        loaded;

    string field_name [NUM_FIELDS] = '{
        "alu_op", "branch", "wb_sel", "reg_write", "mem_read", "mem_write",
        "mem_width", "mem_unsigned", "op_a_pc", "op_b_imm", "illegal",
        "rs1_data", "rs2_data", "imm", "curr_pc", "next_pc", "rs1", "rs2",
        "rd", "instr", "stall_fetch"
    };

    decode_top dut_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr       (instr),
        .curr_pc     (curr_pc),
        .next_pc     (next_pc),
        .wb          (wb),
        .stall_mem   (stall_mem),
        .flush       (flush),
        .id_ex       (id_ex),
        .stall_fetch (stall_fetch)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ##################################################################
    // vector handling
    // ##################################################################

    // each vector takes a stimulus line and then an expected line.
    task automatic load_vectors();
        int    fd;
        int    n;
        bit    want_expect;
        string line;
        fd = $fopen("tb/decode_stim.txt", "r");
        load_ok = (fd != 0);
        want_expect = 1'b0;
        while (load_ok && (vec_count < MAX_VEC) && !$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if ((line.len() < 2) || (line.getc(0) == "#")) begin
                continue;
            end
            if (!want_expect) begin
                n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h", vec_name[vec_count],
                            vec_stim[vec_count][0], vec_stim[vec_count][1],
                            vec_stim[vec_count][2], vec_stim[vec_count][3],
                            vec_stim[vec_count][4], vec_stim[vec_count][5],
                            vec_stim[vec_count][6], vec_stim[vec_count][7],
                            vec_stim[vec_count][8]);
                load_ok = (n == 10);
            end else begin
                n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                            exp_f[vec_count][0], exp_f[vec_count][1], exp_f[vec_count][2],
                            exp_f[vec_count][3], exp_f[vec_count][4], exp_f[vec_count][5],
                            exp_f[vec_count][6], exp_f[vec_count][7], exp_f[vec_count][8],
                            exp_f[vec_count][9], exp_f[vec_count][10], exp_f[vec_count][11],
                            exp_f[vec_count][12], exp_f[vec_count][13], exp_f[vec_count][14],
                            exp_f[vec_count][15], exp_f[vec_count][16], exp_f[vec_count][17],
                            exp_f[vec_count][18], exp_f[vec_count][19], exp_f[vec_count][20]);
                load_ok = (n == NUM_FIELDS);
                vec_count++;
            end
            want_expect = !want_expect;
        end
        if (fd != 0) begin
            $fclose(fd);
        end
        if (want_expect || (vec_count == 0)) begin
            load_ok = 1'b0;
        end
    endtask

    task automatic apply_vector(input int idx);
        instr     = vec_stim[idx][1];
        curr_pc   = vec_stim[idx][2];
        next_pc   = vec_stim[idx][3];
        wb.en     = vec_stim[idx][4][0];
        wb.rd     = vec_stim[idx][5][`DEC_REG_AW-1:0];
        wb.data   = vec_stim[idx][6];
        stall_mem = vec_stim[idx][7][0];
        flush     = vec_stim[idx][8][0];
    endtask

    // same field order as the expected line of the stimulus file.
    function automatic field_vec_t fields_of(input decode_pkg::id_ex_t v, input logic sf);
        field_vec_t f;
        f[0]  = 32'(v.ctrl.alu_op);
        f[1]  = 32'(v.ctrl.branch);
        f[2]  = 32'(v.ctrl.wb_sel);
        f[3]  = 32'(v.ctrl.reg_write);
        f[4]  = 32'(v.ctrl.mem_read);
        f[5]  = 32'(v.ctrl.mem_write);
        f[6]  = 32'(v.ctrl.mem_width);
        f[7]  = 32'(v.ctrl.mem_unsigned);
        f[8]  = 32'(v.ctrl.op_a_pc);
        f[9]  = 32'(v.ctrl.op_b_imm);
        f[10] = 32'(v.ctrl.illegal);
        f[11] = v.rs1_data;
        f[12] = v.rs2_data;
        f[13] = v.imm;
        f[14] = v.curr_pc;
        f[15] = v.next_pc;
        f[16] = 32'(v.rs1);
        f[17] = 32'(v.rs2);
        f[18] = 32'(v.rd);
        f[19] = v.instr;
        f[20] = 32'(sf);
        return f;
    endfunction

    task automatic check_vector(input int idx, input logic sf);
        field_vec_t act;
        act = fields_of(id_ex, sf);
        for (int k = 0; k < NUM_FIELDS; k++) begin
            checks++;
            assert (act[k] == exp_f[idx][k]) else begin
                $display("mismatch test %s vector %0d field %s expected %h actual %h",
                         vec_name[idx], idx, field_name[k], exp_f[idx][k], act[k]);
                errors++;
                test_errors++;
            end
        end
    endtask

    task automatic finish_test(input int idx);
        if (test_errors == 0) begin
            tests_passed++;
            $display("test %s passed", vec_name[idx]);
        end else begin
            tests_failed++;
            $display("test %s failed with %0d errors", vec_name[idx], test_errors);
        end
        test_errors = 0;
    endtask

    // ##################################################################
    // main sequence and watchdog
    // ##################################################################

    initial begin : run_vectors
        logic sf_before_edge;
        clk       = 1'b0;
        rst_n     = 1'b0;
        instr     = '0;
        curr_pc   = '0;
        next_pc   = '0;
        wb        = '0;
        stall_mem = 1'b0;
        flush     = 1'b0;
        loaded    = 1'b0;
        vec_count = 0;
        load_vectors();
        if (!load_ok) begin
            $display("could not read the stimulus vectors from tb/decode_stim.txt");
            $display("TEST FAIL");
        end else begin
            loaded = 1'b1;
            repeat (RESET_CYCLES) @(posedge clk);
            @(negedge clk);
            rst_n = 1'b1;
            for (int i = 0; i < vec_count; i++) begin
                apply_vector(i);
                // stall_fetch as the coming edge sees it.
                #(CLK_PERIOD / 4);
                sf_before_edge = stall_fetch;
                @(posedge clk);
                #1;
                if (vec_stim[i][0][0]) begin
                    check_vector(i, sf_before_edge);
                end
                if ((i == vec_count - 1) || (vec_name[i + 1] != vec_name[i])) begin
                    finish_test(i);
                end
                @(negedge clk);
            end
            $display("summary: %0d tests passed, %0d failed, %0d checks, %0d errors",
                     tests_passed, tests_failed, checks, errors);
            if (tests_failed == 0) begin
                $display("TEST PASS");
            end else begin
                $display("TEST FAIL");
            end
        end
        $finish;
    end

    initial begin : watchdog
        wait (loaded);
        #((RESET_CYCLES + vec_count) * CLK_PERIOD * 4);
        $display("timeout: the vectors did not finish in the expected time");
        $display("TEST FAIL");
        $finish;
    end

endmodule

`default_nettype wire
